//--- tb.f
common/concentrator_pkg.sv
hdl/dual_port_ram.sv
hdl/frame_sequencer.sv
lane/write_queue.sv
lane/lane_port.sv
hdl/read_buffer.sv
hdl/ioc_direct.sv
hdl/data_concentrator.sv
verif/subsystem_model.sv
verif/tb_data_concentrator.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_data_concentrator
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_data_concentrator.sv
`timescale 1ns/1ns
// Testbench driving random host traffic into the data concentrator against lane models
module tb_data_concentrator;
  import concentrator_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int FRAME_CYCLES = 4200;   // Timer strobe spacing
  localparam int N_FRAMES     = 6;      // Last frame only drains writes
  localparam int TIMEOUT_NS   = (N_FRAMES * FRAME_CYCLES + 500) * CLK_PERIOD;
  localparam int SEQ_READS    = 3 * 128;  // Sequenced reads per frame

  logic                  clk;
  logic                  reset;
  logic                  enable;
  logic                  sys_tmr_strb;
  word_t                 rd_data;
  logic                  rd_strb;
  host_addr_t            rd_addr;
  logic                  wr_strb;
  host_addr_t            wr_addr;
  word_t                 wr_data;
  logic [SUB_ADDR_W-1:0] cmd_con_addr, cmd_saf_addr, cmd_uic_addr, cmd_ioc_addr;
  logic                  cmd_con_rd_strb, cmd_saf_rd_strb, cmd_uic_rd_strb, cmd_ioc_rd_strb;
  logic                  cmd_con_wr_strb, cmd_saf_wr_strb, cmd_uic_wr_strb, cmd_ioc_wr_strb;
  word_t                 cmd_con_wr_data, cmd_saf_wr_data, cmd_uic_wr_data, cmd_ioc_wr_data;
  word_t                 cmd_con_rd_data, cmd_saf_rd_data, cmd_uic_rd_data, ioc_rd_data;
  logic                  cmd_con_rdy, cmd_saf_rdy, cmd_uic_rdy;

  // --------------------
  // Reference state
  // --------------------
  integer    seed = 32'h7b6f;
  int        errors;
  int        cyc;              // Cycles since last timer strobe
  int        frames_sent;
  logic      fill_bank;        // Bank the sequencer fills
  int        rd_seq;           // Sequenced reads seen this frame
  word_t     snap [2][4][128]; // Register values at sequenced read time
  wr_entry_t pend_q [4][$];    // Pushed this frame
  wr_entry_t due_q  [4][$];    // Owed to the lane this frame
  int        frame_wr_seen;
  int        n_host_rd, n_ioc_ops, n_pushed;
  int        ioc_hold_left;    // Stretch cycles still owed
  reg_idx_t  ioc_hold_idx;     // Index of the last IOC write

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  data_concentrator #(.msg_time(16'd8)) data_concentrator_i
  (
    .clk (clk), .reset (reset), .enable_i (enable), .sys_tmr_strb_i (sys_tmr_strb),
    .rd_data_o (rd_data), .rd_strb_i (rd_strb), .rd_addr_i (rd_addr),
    .wr_strb_i (wr_strb), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
    .cmd_uic_addr_o (cmd_uic_addr), .cmd_uic_rd_strb_o (cmd_uic_rd_strb),
    .cmd_uic_wr_strb_o (cmd_uic_wr_strb), .cmd_uic_wr_data_o (cmd_uic_wr_data),
    .cmd_uic_rd_data_i (cmd_uic_rd_data), .cmd_uic_rdy_strb_i (cmd_uic_rdy),
    .cmd_con_addr_o (cmd_con_addr), .cmd_con_rd_strb_o (cmd_con_rd_strb),
    .cmd_con_wr_strb_o (cmd_con_wr_strb), .cmd_con_wr_data_o (cmd_con_wr_data),
    .cmd_con_rd_data_i (cmd_con_rd_data), .cmd_con_rdy_strb_i (cmd_con_rdy),
    .cmd_saf_addr_o (cmd_saf_addr), .cmd_saf_rd_strb_o (cmd_saf_rd_strb),
    .cmd_saf_wr_strb_o (cmd_saf_wr_strb), .cmd_saf_wr_data_o (cmd_saf_wr_data),
    .cmd_saf_rd_data_i (cmd_saf_rd_data), .cmd_saf_rdy_strb_i (cmd_saf_rdy),
    .cmd_ioc_addr_o (cmd_ioc_addr), .cmd_ioc_rd_strb_o (cmd_ioc_rd_strb),
    .cmd_ioc_wr_strb_o (cmd_ioc_wr_strb), .cmd_ioc_wr_data_o (cmd_ioc_wr_data),
    .cmd_ioc_rd_data_i (ioc_rd_data)
  );

  subsystem_model #(.lane(LANE_CON)) con_model
  (
    .clk (clk), .reset (reset), .addr_i (cmd_con_addr), .rd_strb_i (cmd_con_rd_strb),
    .wr_strb_i (cmd_con_wr_strb), .wr_data_i (cmd_con_wr_data),
    .rd_data_o (cmd_con_rd_data), .rdy_strb_o (cmd_con_rdy)
  );

  subsystem_model #(.lane(LANE_SAF)) saf_model
  (
    .clk (clk), .reset (reset), .addr_i (cmd_saf_addr), .rd_strb_i (cmd_saf_rd_strb),
    .wr_strb_i (cmd_saf_wr_strb), .wr_data_i (cmd_saf_wr_data),
    .rd_data_o (cmd_saf_rd_data), .rdy_strb_o (cmd_saf_rdy)
  );

  subsystem_model #(.lane(LANE_UIC)) uic_model
  (
    .clk (clk), .reset (reset), .addr_i (cmd_uic_addr), .rd_strb_i (cmd_uic_rd_strb),
    .wr_strb_i (cmd_uic_wr_strb), .wr_data_i (cmd_uic_wr_data),
    .rd_data_o (cmd_uic_rd_data), .rdy_strb_o (cmd_uic_rdy)
  );

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // --------------------
  // Lane bus monitor
  // --------------------
  task automatic observe_lane(input lane_t lane, input string nm, input logic rd,
                              input logic wr, input logic [15:0] addr,
                              input word_t data, input word_t reg_now);
    lane_t     exp_lane;
    wr_entry_t exp_e;
    if (rd)
    begin
      exp_lane = lane_t'(1 + rd_seq / 128);   // Con block, then saf, then uic
      if (rd_seq >= SEQ_READS)
        report_error($sformatf("extra read strobe on %s lane", nm));
      else if (lane != exp_lane)
        report_error($sformatf("read on %s lane while lane %0d was due", nm, exp_lane));
      else if (addr !== 16'(rd_seq % 128))
        report_mismatch($sformatf("cmd_%s_addr_o", nm), word_t'(addr),
                        word_t'(rd_seq % 128));
      snap[fill_bank][lane][addr[6:0]] = reg_now;
      rd_seq++;
    end
    if (wr)
    begin
      frame_wr_seen++;
      if (due_q[lane].size() == 0)
        report_error($sformatf("write on %s lane with nothing queued for it", nm));
      else
      begin
        exp_e = due_q[lane].pop_front();      // Push order
        if (addr !== 16'(exp_e.idx))
          report_mismatch($sformatf("cmd_%s_addr_o", nm), word_t'(addr),
                          word_t'(exp_e.idx));
        if (data !== exp_e.data)
          report_mismatch($sformatf("cmd_%s_wr_data_o", nm), data, exp_e.data);
      end
    end
  endtask

  // IOC write index stays on the bus for two cycles after the strobe
  task automatic check_ioc_hold();
    if (cmd_ioc_wr_strb)
    begin
      ioc_hold_left = 2;
      ioc_hold_idx  = wr_addr[6:0];
    end
    else if (ioc_hold_left > 0)
    begin
      if (!cmd_ioc_rd_strb && cmd_ioc_addr !== 16'(ioc_hold_idx))
        report_mismatch("cmd_ioc_addr_o", word_t'(cmd_ioc_addr), word_t'(ioc_hold_idx));
      ioc_hold_left--;
    end
  endtask

  always @(posedge clk)
  begin
    if (sys_tmr_strb)
      rd_seq = 0;
    if (!reset)
    begin
      observe_lane(LANE_CON, "con", cmd_con_rd_strb, cmd_con_wr_strb, cmd_con_addr,
                   cmd_con_wr_data, con_model.regs[cmd_con_addr[6:0]]);
      observe_lane(LANE_SAF, "saf", cmd_saf_rd_strb, cmd_saf_wr_strb, cmd_saf_addr,
                   cmd_saf_wr_data, saf_model.regs[cmd_saf_addr[6:0]]);
      observe_lane(LANE_UIC, "uic", cmd_uic_rd_strb, cmd_uic_wr_strb, cmd_uic_addr,
                   cmd_uic_wr_data, uic_model.regs[cmd_uic_addr[6:0]]);
      check_ioc_hold();
    end
  end

  // --------------------
  // Host stimulus
  // --------------------
  task automatic step();
    @(posedge clk);
    #2;                              // Drive point
    cyc++;
  endtask

  task automatic remote_read(input lane_t lane, input reg_idx_t idx);
    rd_strb = 1'b1;
    rd_addr = {lane, idx};
    step();
    rd_strb = 1'b0;                  // Address held a second cycle
    #8;
    n_host_rd++;
    if (frames_sent >= 2 && rd_data !== snap[~fill_bank][lane][idx])
      report_mismatch("rd_data_o", rd_data, snap[~fill_bank][lane][idx]);
    step();
  endtask

  task automatic ioc_read(input reg_idx_t idx, input word_t data);
    rd_strb     = 1'b1;
    rd_addr     = {LANE_IOC, idx};
    ioc_rd_data = data;
    #8;
    n_ioc_ops++;
    if (cmd_ioc_rd_strb !== 1'b1)
      report_mismatch("cmd_ioc_rd_strb_o", word_t'(cmd_ioc_rd_strb), 36'd1);
    if (cmd_ioc_addr !== 16'(idx))
      report_mismatch("cmd_ioc_addr_o", word_t'(cmd_ioc_addr), word_t'(idx));
    if (rd_data !== data)
      report_mismatch("rd_data_o", rd_data, data);   // Pass-through
    step();
    rd_strb = 1'b0;
  endtask

  task automatic remote_write(input lane_t lane, input reg_idx_t idx, input word_t data);
    wr_entry_t e;
    e.idx   = idx;
    e.data  = data;
    wr_strb = 1'b1;
    wr_addr = {lane, idx};
    wr_data = data;
    if (pend_q[lane].size() < QUEUE_DEPTH)
    begin
      pend_q[lane].push_back(e);     // A full bank drops the rest
      n_pushed++;
    end
    #8;
    if (cmd_ioc_wr_strb !== 1'b0)
      report_mismatch("cmd_ioc_wr_strb_o", word_t'(cmd_ioc_wr_strb), 36'd0);
    step();
    wr_strb = 1'b0;
  endtask

  task automatic ioc_write(input reg_idx_t idx, input word_t data);
    wr_strb = 1'b1;
    wr_addr = {LANE_IOC, idx};
    wr_data = data;
    #8;
    n_ioc_ops++;
    if (cmd_ioc_wr_strb !== 1'b1)
      report_mismatch("cmd_ioc_wr_strb_o", word_t'(cmd_ioc_wr_strb), 36'd1);
    if (cmd_ioc_wr_data !== data)
      report_mismatch("cmd_ioc_wr_data_o", cmd_ioc_wr_data, data);
    if (cmd_ioc_addr !== 16'(idx))
      report_mismatch("cmd_ioc_addr_o", word_t'(cmd_ioc_addr), word_t'(idx));
    step();
    wr_strb = 1'b0;
  endtask

  task automatic random_op();
    logic [31:0] r;
    logic [31:0] d;
    lane_t       lane;
    reg_idx_t    idx;
    word_t       data;
    r    = $random(seed);
    d    = $random(seed);
    lane = lane_t'(8'd1 + r[15:8] % 8'd3);   // Remote lanes only
    idx  = r[22:16];
    data = {r[27:24], d};
    case (r[2:0])
      3'd0, 3'd1: remote_read(lane, idx);
      3'd2:       ioc_read(idx, data);
      3'd3:       remote_write(lane, idx, data);
      3'd4:       ioc_write(idx, data);
      default:    step();              // Idle cycle
    endcase
  endtask

  // Frame bookkeeping, one report line per frame
  task automatic finish_frame();
    if (rd_seq != SEQ_READS)
      report_error($sformatf("frame had %0d sequenced reads, not %0d", rd_seq, SEQ_READS));
    for (int l = 1; l < 4; l++)
    begin
      if (due_q[l].size() != 0)
        report_error($sformatf("%0d writes never reached lane %0d", due_q[l].size(), l));
    end
    $display("frame %0d done: %0d lane reads, %0d lane writes, %0d errors so far",
             frames_sent, rd_seq, frame_wr_seen, errors);
    frame_wr_seen = 0;
  endtask

  task automatic start_frame();
    if (frames_sent > 0)
      finish_frame();
    for (int l = 1; l < 4; l++)
    begin
      due_q[l] = pend_q[l];          // Delivered in the coming frame
      pend_q[l].delete();
    end
    sys_tmr_strb = 1'b1;
    fill_bank    = ~fill_bank;
    frames_sent++;
    cyc = 0;
    step();
    sys_tmr_strb = 1'b0;
  endtask

  initial
  begin
    enable        = 1'b1;
    sys_tmr_strb  = 1'b0;
    rd_strb       = 1'b0;
    rd_addr       = '0;
    wr_strb       = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    ioc_rd_data   = '0;
    errors        = 0;
    frames_sent   = 0;
    fill_bank     = 1'b0;
    rd_seq        = 0;
    frame_wr_seen = 0;
    n_host_rd     = 0;
    n_ioc_ops     = 0;
    n_pushed      = 0;
    ioc_hold_left = 0;
    ioc_hold_idx  = '0;
    reset         = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    step();
    #8;
    if ({cmd_con_rd_strb, cmd_con_wr_strb, cmd_saf_rd_strb, cmd_saf_wr_strb,
         cmd_uic_rd_strb, cmd_uic_wr_strb, cmd_ioc_rd_strb, cmd_ioc_wr_strb} !== 8'd0)
      report_mismatch("cmd strobes", word_t'({cmd_con_rd_strb, cmd_con_wr_strb,
                      cmd_saf_rd_strb, cmd_saf_wr_strb, cmd_uic_rd_strb,
                      cmd_uic_wr_strb, cmd_ioc_rd_strb, cmd_ioc_wr_strb}), '0);
    $display("reset test done: %0d errors", errors);
    step();
    for (int f = 0; f < N_FRAMES; f++)
    begin
      start_frame();
      while (cyc < FRAME_CYCLES)
      begin
        if (f == N_FRAMES - 1 || cyc >= FRAME_CYCLES - 4)
          step();                    // Quiet before the strobe
        else
          random_op();
      end
    end
    finish_frame();
    $display("totals: %0d frames, %0d host reads, %0d ioc ops, %0d pushes, %0d errors",
             frames_sent, n_host_rd, n_ioc_ops, n_pushed, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog, all frames plus a margin
  initial
  begin
    #(TIMEOUT_NS);
    $display("ERROR: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verif/subsystem_model.sv
`timescale 1ns/1ns
// Remote subsystem register file model answering reads two cycles after the strobe
module subsystem_model
  import concentrator_pkg::*;
#(
  parameter lane_t lane = LANE_CON   // Tags the fill pattern
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [SUB_ADDR_W-1:0] addr_i,
  input  logic                  rd_strb_i,
  input  logic                  wr_strb_i,
  input  word_t                 wr_data_i,
  output word_t                 rd_data_o,
  output logic                  rdy_strb_o
);

  word_t regs [128];     // Register file, one word per index
  logic  rd_z1_q;        // Reply pipeline stage
  word_t rd_z1_data_q;

  // Fill pattern over the whole index, lane code on top
  initial
  begin
    for (int i = 0; i < 128; i++)
      regs[i] = {lane, 2'b10, 25'(i * 32'h2f1b3), 7'(i)};
    rd_z1_data_q = '0;
    rd_data_o    = '0;
  end

  // Writes land at the edge after the strobe
  always @(posedge clk)
  begin
    if (wr_strb_i)
      regs[addr_i[6:0]] <= wr_data_i;
  end

  // --------------------
  // Two-cycle reply
  // --------------------
  always @(posedge clk)
  begin
    if (reset)
    begin
      rd_z1_q    <= 1'b0;
      rdy_strb_o <= 1'b0;
    end
    else
    begin
      rd_z1_q    <= rd_strb_i;
      rdy_strb_o <= rd_z1_q;         // Rdy two cycles after the read strobe
    end
    if (rd_strb_i)
      rd_z1_data_q <= regs[addr_i[6:0]];  // Value as it stood at the strobe
    rd_data_o <= rd_z1_data_q;
  end

endmodule

//--- hdl/data_concentrator.sv
`timescale 1ns/1ns
// Register data concentrator top joining sequencer, remote lanes, buffer and IOC
module data_concentrator
  import concentrator_pkg::*;
#(
  parameter logic [15:0] msg_time = MSG_TIME_DEFAULT
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable_i,
  input  logic                  sys_tmr_strb_i,     // Frame start
  // Host port
  output word_t                 rd_data_o,
  input  logic                  rd_strb_i,
  input  host_addr_t            rd_addr_i,
  input  logic                  wr_strb_i,
  input  host_addr_t            wr_addr_i,
  input  word_t                 wr_data_i,
  // User interface lane
  output logic [SUB_ADDR_W-1:0] cmd_uic_addr_o,
  output logic                  cmd_uic_rd_strb_o,
  output logic                  cmd_uic_wr_strb_o,
  output word_t                 cmd_uic_wr_data_o,
  input  word_t                 cmd_uic_rd_data_i,
  input  logic                  cmd_uic_rdy_strb_i,
  // Control lane
  output logic [SUB_ADDR_W-1:0] cmd_con_addr_o,
  output logic                  cmd_con_rd_strb_o,
  output logic                  cmd_con_wr_strb_o,
  output word_t                 cmd_con_wr_data_o,
  input  word_t                 cmd_con_rd_data_i,
  input  logic                  cmd_con_rdy_strb_i,
  // Safety lane
  output logic [SUB_ADDR_W-1:0] cmd_saf_addr_o,
  output logic                  cmd_saf_rd_strb_o,
  output logic                  cmd_saf_wr_strb_o,
  output word_t                 cmd_saf_wr_data_o,
  input  word_t                 cmd_saf_rd_data_i,
  input  logic                  cmd_saf_rdy_strb_i,
  // IO controller, direct
  output logic [SUB_ADDR_W-1:0] cmd_ioc_addr_o,
  output logic                  cmd_ioc_rd_strb_o,
  output logic                  cmd_ioc_wr_strb_o,
  output word_t                 cmd_ioc_wr_data_o,
  input  word_t                 cmd_ioc_rd_data_i
);

  lane_t    slot;
  reg_idx_t index;
  logic     action_strb;
  logic     frame_done;
  logic     bank;

  frame_sequencer #(.msg_time(msg_time)) frame_sequencer_i
  (
    .clk            (clk),
    .reset          (reset),
    .enable_i       (enable_i),
    .sys_tmr_strb_i (sys_tmr_strb_i),
    .slot_o         (slot),
    .index_o        (index),
    .action_strb_o  (action_strb),
    .frame_done_o   (frame_done),
    .bank_o         (bank)
  );

  // --------------------
  // Remote lanes
  // --------------------
  lane_port #(.lane(LANE_CON), .wr_slot(WR_SLOT_CON)) lane_con_i
  (
    .clk (clk), .reset (reset), .slot_i (slot), .index_i (index),
    .action_strb_i (action_strb), .bank_i (bank), .frame_done_i (frame_done),
    .wr_strb_i (wr_strb_i), .wr_addr_i (wr_addr_i), .wr_data_i (wr_data_i),
    .cmd_addr_o (cmd_con_addr_o), .cmd_rd_strb_o (cmd_con_rd_strb_o),
    .cmd_wr_strb_o (cmd_con_wr_strb_o), .cmd_wr_data_o (cmd_con_wr_data_o)
  );

  lane_port #(.lane(LANE_SAF), .wr_slot(WR_SLOT_SAF)) lane_saf_i
  (
    .clk (clk), .reset (reset), .slot_i (slot), .index_i (index),
    .action_strb_i (action_strb), .bank_i (bank), .frame_done_i (frame_done),
    .wr_strb_i (wr_strb_i), .wr_addr_i (wr_addr_i), .wr_data_i (wr_data_i),
    .cmd_addr_o (cmd_saf_addr_o), .cmd_rd_strb_o (cmd_saf_rd_strb_o),
    .cmd_wr_strb_o (cmd_saf_wr_strb_o), .cmd_wr_data_o (cmd_saf_wr_data_o)
  );

  lane_port #(.lane(LANE_UIC), .wr_slot(WR_SLOT_UIC)) lane_uic_i
  (
    .clk (clk), .reset (reset), .slot_i (slot), .index_i (index),
    .action_strb_i (action_strb), .bank_i (bank), .frame_done_i (frame_done),
    .wr_strb_i (wr_strb_i), .wr_addr_i (wr_addr_i), .wr_data_i (wr_data_i),
    .cmd_addr_o (cmd_uic_addr_o), .cmd_rd_strb_o (cmd_uic_rd_strb_o),
    .cmd_wr_strb_o (cmd_uic_wr_strb_o), .cmd_wr_data_o (cmd_uic_wr_data_o)
  );

  read_buffer read_buffer_i
  (
    .clk (clk), .reset (reset), .slot_i (slot), .index_i (index), .bank_i (bank),
    .con_rd_data_i (cmd_con_rd_data_i), .con_rdy_strb_i (cmd_con_rdy_strb_i),
    .saf_rd_data_i (cmd_saf_rd_data_i), .saf_rdy_strb_i (cmd_saf_rdy_strb_i),
    .uic_rd_data_i (cmd_uic_rd_data_i), .uic_rdy_strb_i (cmd_uic_rdy_strb_i),
    .rd_addr_i     (rd_addr_i),
    .ioc_rd_data_i (cmd_ioc_rd_data_i),
    .rd_data_o     (rd_data_o)
  );

  ioc_direct ioc_direct_i
  (
    .clk (clk), .reset (reset),
    .rd_strb_i (rd_strb_i), .rd_addr_i (rd_addr_i),
    .wr_strb_i (wr_strb_i), .wr_addr_i (wr_addr_i), .wr_data_i (wr_data_i),
    .cmd_ioc_addr_o    (cmd_ioc_addr_o),
    .cmd_ioc_rd_strb_o (cmd_ioc_rd_strb_o),
    .cmd_ioc_wr_strb_o (cmd_ioc_wr_strb_o),
    .cmd_ioc_wr_data_o (cmd_ioc_wr_data_o)
  );

endmodule

//--- hdl/ioc_direct.sv
`timescale 1ns/1ns
// Direct IO controller access with the write address held for three cycles
module ioc_direct
  import concentrator_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rd_strb_i,
  input  host_addr_t            rd_addr_i,
  input  logic                  wr_strb_i,
  input  host_addr_t            wr_addr_i,
  input  word_t                 wr_data_i,
  output logic [SUB_ADDR_W-1:0] cmd_ioc_addr_o,
  output logic                  cmd_ioc_rd_strb_o,
  output logic                  cmd_ioc_wr_strb_o,
  output word_t                 cmd_ioc_wr_data_o
);

  logic     wr_z1_q;    // Write stretch stages
  logic     wr_z2_q;
  reg_idx_t wr_idx_q;   // Held write index

  assign cmd_ioc_rd_strb_o = rd_strb_i & (rd_addr_i[8:7] == LANE_IOC);
  assign cmd_ioc_wr_strb_o = wr_strb_i & (wr_addr_i[8:7] == LANE_IOC);
  assign cmd_ioc_wr_data_o = wr_data_i;  // Straight through

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_z1_q <= 1'b0;
      wr_z2_q <= 1'b0;
    end
    else
    begin
      wr_z1_q <= cmd_ioc_wr_strb_o;
      wr_z2_q <= wr_z1_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_ioc_wr_strb_o)
      wr_idx_q <= wr_addr_i[6:0];
  end

  // Address select, a new read wins over the stretch
  always_comb
  begin
    if (cmd_ioc_wr_strb_o)
      cmd_ioc_addr_o = SUB_ADDR_W'(wr_addr_i[6:0]);
    else if (cmd_ioc_rd_strb_o)
      cmd_ioc_addr_o = SUB_ADDR_W'(rd_addr_i[6:0]);
    else if (wr_z1_q || wr_z2_q)
      cmd_ioc_addr_o = SUB_ADDR_W'(wr_idx_q);
    else
      cmd_ioc_addr_o = SUB_ADDR_W'(rd_addr_i[6:0]);
  end

endmodule

//--- hdl/read_buffer.sv
`timescale 1ns/1ns
// Ping-pong read buffer capturing lane replies and serving host reads
module read_buffer
  import concentrator_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  lane_t      slot_i,
  input  reg_idx_t   index_i,
  input  logic       bank_i,           // Bank being filled
  input  word_t      con_rd_data_i,
  input  logic       con_rdy_strb_i,
  input  word_t      saf_rd_data_i,
  input  logic       saf_rdy_strb_i,
  input  word_t      uic_rd_data_i,
  input  logic       uic_rdy_strb_i,
  input  host_addr_t rd_addr_i,        // Host read address
  input  word_t      ioc_rd_data_i,    // Direct IOC data
  output word_t      rd_data_o
);

  word_t     reply;
  logic      reply_rdy;
  word_t     cap_data_q;
  logic      cap_wr_q;
  buf_addr_t cap_addr;
  buf_addr_t host_rd_addr;
  word_t     buf_data;

  // --------------------
  // Reply of the active lane
  // --------------------
  always_comb
  begin
    reply     = '0;
    reply_rdy = 1'b0;
    case (slot_i)
      LANE_CON:
      begin
        reply     = con_rd_data_i;
        reply_rdy = con_rdy_strb_i;
      end
      LANE_SAF:
      begin
        reply     = saf_rd_data_i;
        reply_rdy = saf_rdy_strb_i;
      end
      LANE_UIC:
      begin
        reply     = uic_rd_data_i;
        reply_rdy = uic_rdy_strb_i;
      end
      default:
      begin
        reply     = '0;                 // IOC slot reads nothing
        reply_rdy = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reply_rdy)
      cap_data_q <= reply;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      cap_wr_q <= 1'b0;
    else
      cap_wr_q <= reply_rdy;           // RAM write one cycle after rdy
  end

  assign cap_addr     = {bank_i, slot_i, index_i};
  assign host_rd_addr = {~bank_i, rd_addr_i};    // Host sees last full frame

  dual_port_ram
  #(
    .data_t (word_t),
    .depth  (2 ** $bits(buf_addr_t))
  )
  buf_ram_i
  (
    .clk       (clk),
    .wr_i      (cap_wr_q),
    .wr_addr_i (cap_addr),
    .wr_data_i (cap_data_q),
    .rd_addr_i (host_rd_addr),
    .rd_data_o (buf_data)
  );

  // IOC reads bypass the buffer
  assign rd_data_o = (rd_addr_i[8:7] == LANE_IOC) ? ioc_rd_data_i : buf_data;

endmodule

//--- lane/lane_port.sv
`timescale 1ns/1ns
// Remote lane command generator issuing sequenced reads and queued writes
module lane_port
  import concentrator_pkg::*;
#(
  parameter lane_t lane    = LANE_CON,     // Own lane code and read slot
  parameter lane_t wr_slot = WR_SLOT_CON   // Slot where queued writes go out
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  lane_t                 slot_i,
  input  reg_idx_t              index_i,
  input  logic                  action_strb_i,
  input  logic                  bank_i,
  input  logic                  frame_done_i,
  input  logic                  wr_strb_i,     // Host write
  input  host_addr_t            wr_addr_i,
  input  word_t                 wr_data_i,
  output logic [SUB_ADDR_W-1:0] cmd_addr_o,
  output logic                  cmd_rd_strb_o,
  output logic                  cmd_wr_strb_o,
  output word_t                 cmd_wr_data_o
);

  logic      push;
  logic      pop;
  logic      q_empty;
  wr_entry_t push_entry;
  wr_entry_t pop_entry;

  assign push       = wr_strb_i & (wr_addr_i[8:7] == lane);  // Host write to this lane
  assign push_entry = '{idx: wr_addr_i[6:0], data: wr_data_i};
  assign pop        = action_strb_i & (slot_i == wr_slot) & ~q_empty;

  write_queue write_queue_i
  (
    .clk          (clk),
    .reset        (reset),
    .push_i       (push),
    .push_entry_i (push_entry),
    .push_bank_i  (~bank_i),       // Host fills the other bank
    .pop_i        (pop),
    .pop_bank_i   (bank_i),
    .clear_i      (frame_done_i),
    .empty_o      (q_empty),
    .pop_entry_o  (pop_entry)
  );

  // Strobes one cycle after the action strobe
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cmd_rd_strb_o <= 1'b0;
      cmd_wr_strb_o <= 1'b0;
    end
    else
    begin
      cmd_rd_strb_o <= action_strb_i & (slot_i == lane);
      cmd_wr_strb_o <= pop;            // Entry leaves the RAM with it
    end
  end

  // Queue index in the write slot, sequence index otherwise
  always_comb
  begin
    if (slot_i == wr_slot)
      cmd_addr_o = SUB_ADDR_W'(pop_entry.idx);
    else
      cmd_addr_o = SUB_ADDR_W'(index_i);
  end

  assign cmd_wr_data_o = pop_entry.data;

  assert property (@(posedge clk) disable iff (reset) !(cmd_rd_strb_o && cmd_wr_strb_o));

endmodule

//--- lane/write_queue.sv
`timescale 1ns/1ns
// Two-bank write queue holding host writes for one remote lane in one RAM
module write_queue
  import concentrator_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      push_i,
  input  wr_entry_t push_entry_i,
  input  logic      push_bank_i,   // Host bank
  input  logic      pop_i,
  input  logic      pop_bank_i,    // Bank being drained
  input  logic      clear_i,       // Empties the pop bank
  output logic      empty_o,       // Pop bank has nothing left
  output wr_entry_t pop_entry_o    // Valid the cycle after pop_i
);

  logic [QUEUE_PTR_W:0]   head_q [2];  // Next entry to pop, per bank
  logic [QUEUE_PTR_W:0]   tail_q [2];  // Next free entry, per bank
  logic [QUEUE_PTR_W:0]   push_ptr;
  logic [QUEUE_PTR_W:0]   pop_ptr;
  logic                   push_ok;
  logic [QUEUE_PTR_W:0]   ram_wr_addr;
  logic [QUEUE_PTR_W:0]   ram_rd_addr;

  assign push_ptr = tail_q[push_bank_i];
  assign pop_ptr  = head_q[pop_bank_i];
  assign push_ok  = push_i & (push_ptr != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));  // Full drops
  assign empty_o  = (pop_ptr == tail_q[pop_bank_i]);

  // RAM address is bank bit over index
  assign ram_wr_addr = {push_bank_i, push_ptr[QUEUE_PTR_W-1:0]};
  assign ram_rd_addr = {pop_bank_i, pop_ptr[QUEUE_PTR_W-1:0]};

  // --------------------
  // Pointers
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      head_q <= '{default: '0};
      tail_q <= '{default: '0};
    end
    else
    begin
      if (push_ok)
        tail_q[push_bank_i] <= push_ptr + 1'b1;
      if (clear_i)
      begin
        head_q[pop_bank_i] <= '0;       // Drained bank reopens for the host
        tail_q[pop_bank_i] <= '0;
      end
      else if (pop_i)
        head_q[pop_bank_i] <= pop_ptr + 1'b1;
    end
  end

  dual_port_ram
  #(
    .data_t (wr_entry_t),
    .depth  (2 * QUEUE_DEPTH)
  )
  entry_ram_i
  (
    .clk       (clk),
    .wr_i      (push_ok),
    .wr_addr_i (ram_wr_addr),
    .wr_data_i (push_entry_i),
    .rd_addr_i (ram_rd_addr),    // Head entry always on the output
    .rd_data_o (pop_entry_o)
  );

  // Lane never pops an empty bank
  assert property (@(posedge clk) disable iff (reset) pop_i |-> !empty_o);

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ns
// Frame sequencer pacing 512 message slots per system timer frame
module frame_sequencer
  import concentrator_pkg::*;
#(
  parameter logic [15:0] msg_time = MSG_TIME_DEFAULT  // Clocks per slot
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     enable_i,
  input  logic     sys_tmr_strb_i,  // Frame start
  output lane_t    slot_o,          // Lane whose slot is active
  output reg_idx_t index_o,         // Register index within the slot
  output logic     action_strb_o,   // Issue bus action now
  output logic     frame_done_o,    // Last slot finished
  output logic     bank_o           // Bank the sequencer fills
);

  logic [15:0] msg_tmr_q;
  logic [8:0]  seq_q;
  logic        running_q;
  logic        tmr_run;
  logic        msg_wrap;
  logic        seq_last;

  assign tmr_run  = running_q & enable_i;
  assign msg_wrap = tmr_run & (msg_tmr_q == msg_time - 16'd1);  // End of one slot
  assign seq_last = (seq_q == SEQ_LAST);

  assign slot_o  = seq_q[8:7];
  assign index_o = seq_q[6:0];

  // --------------------
  // Message timer
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset || sys_tmr_strb_i)
      msg_tmr_q <= '0;                  // Restart on every frame
    else if (msg_wrap)
      msg_tmr_q <= '0;
    else if (tmr_run)
      msg_tmr_q <= msg_tmr_q + 16'd1;
  end

  // --------------------
  // Slot counter and run flag
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      seq_q     <= '0;
      running_q <= 1'b0;
    end
    else if (sys_tmr_strb_i)
    begin
      seq_q     <= '0;
      running_q <= 1'b1;
    end
    else if (msg_wrap)
    begin
      seq_q <= seq_q + 9'd1;            // Wraps to 0 past SEQ_LAST
      if (seq_last)
        running_q <= 1'b0;              // Idle until next timer strobe
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      frame_done_o  <= 1'b0;
      action_strb_o <= 1'b0;
    end
    else
    begin
      frame_done_o  <= msg_wrap & seq_last & ~sys_tmr_strb_i;
      action_strb_o <= tmr_run & (msg_tmr_q == 16'd1);  // Once per slot
    end
  end

  // Ping-pong bank, flips at each frame start
  always_ff @(posedge clk)
  begin
    if (reset)
      bank_o <= 1'b0;
    else if (sys_tmr_strb_i)
      bank_o <= ~bank_o;
  end

  // No bus action outside a running frame
  assert property (@(posedge clk) disable iff (reset) action_strb_o |-> running_q);

endmodule

//--- hdl/dual_port_ram.sv
`timescale 1ns/1ns
// Simple dual-port block RAM with one write port and one registered read port
module dual_port_ram
#(
  parameter type data_t = logic [7:0],  // Payload carried per entry
  parameter int  depth  = 256
)
(
  input  logic                     clk,
  input  logic                     wr_i,       // Write enable
  input  logic [$clog2(depth)-1:0] wr_addr_i,
  input  data_t                    wr_data_i,
  input  logic [$clog2(depth)-1:0] rd_addr_i,
  output data_t                    rd_data_o   // One cycle after rd_addr_i
);

  data_t mem [depth];  // Inferred block memory

  // Write port
  always_ff @(posedge clk)
  begin
    if (wr_i)
      mem[wr_addr_i] <= wr_data_i;
  end

  // Read port, always enabled
  always_ff @(posedge clk)
  begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- common/concentrator_pkg.sv
// Register data concentrator shared types, lane codes and timing constants
package concentrator_pkg;

  // ------------------
  // Data and addresses
  // ------------------
  typedef logic [35:0] word_t;       // One subsystem register
  typedef logic [8:0]  host_addr_t;  // Lane code over register index
  typedef logic [1:0]  lane_t;
  typedef logic [6:0]  reg_idx_t;
  typedef logic [9:0]  buf_addr_t;   // Bank bit, lane code, index

  // Queued host write
  typedef struct packed {
    reg_idx_t idx;   // Target register
    word_t    data;  // Value to write
  } wr_entry_t;

  localparam int SUB_ADDR_W = 16;  // Subsystem bus, upper bits stay zero

  // ------------------
  // Lane codes
  // ------------------
  localparam lane_t LANE_IOC = 2'd0;  // Direct, never sequenced
  localparam lane_t LANE_CON = 2'd1;
  localparam lane_t LANE_SAF = 2'd2;
  localparam lane_t LANE_UIC = 2'd3;

  // Write slots sit in another lane's read slot
  // so one bus never sees a read and a write together
  localparam lane_t WR_SLOT_UIC = 2'd0;
  localparam lane_t WR_SLOT_SAF = 2'd1;
  localparam lane_t WR_SLOT_CON = 2'd2;

  // ------------------
  // Queue and timing
  // ------------------
  localparam int QUEUE_DEPTH = 128;                  // Entries per bank
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);  // Index bits into one bank

  localparam logic [15:0] MSG_TIME_DEFAULT = 16'h490C;  // Clocks per message slot
  localparam logic [8:0]  SEQ_LAST         = 9'd511;    // Final slot of a frame

endpackage
